/* verilog/cordic_pkg.sv */
package cordic_pkg;

    localparam int DATA_W  = 16;  // operand and angle width
    localparam int ITER_N  = 16;  // cordic iterations
    localparam int ITER_W  = 4;   // iteration counter width
    localparam int GUARD_W = 3;   // fraction bits kept below the operand lsb

    // sign, two growth bits for the cordic gain, folded magnitude, guard bits
    localparam int XY_W = DATA_W + 4 + GUARD_W;

    // atan(2^-i) / pi, scaled by 2^15
    localparam logic signed [DATA_W-1:0] ATAN_TABLE [ITER_N] = '{
        16'sd8192, 16'sd4836, 16'sd2555, 16'sd1297,
        16'sd651,  16'sd326,  16'sd163,  16'sd81,
        16'sd41,   16'sd20,   16'sd10,   16'sd5,
        16'sd3,    16'sd1,    16'sd1,    16'sd0
    };

    localparam logic signed [DATA_W-1:0] HALF_TURN = 16'sd32767;  // +pi

endpackage

/* verilog/axil_pkg.sv */
package axil_pkg;

    localparam int AXI_ADDR_W = 5;
    localparam int AXI_DATA_W = 32;

    // register map
    localparam logic [AXI_ADDR_W-1:0] ADDR_X      = 5'h00;
    localparam logic [AXI_ADDR_W-1:0] ADDR_Y      = 5'h04;
    localparam logic [AXI_ADDR_W-1:0] ADDR_CTRL   = 5'h08;  // bit 0 starts a job
    localparam logic [AXI_ADDR_W-1:0] ADDR_STATUS = 5'h0C;  // bit 0 busy, bit 1 done
    localparam logic [AXI_ADDR_W-1:0] ADDR_RESULT = 5'h10;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

endpackage

/* verilog/axil_if.sv */
interface axil_if import axil_pkg::*; ();
    logic [AXI_ADDR_W-1:0]   awaddr;
    logic                    awvalid;
    logic                    awready;
    logic [AXI_DATA_W-1:0]   wdata;
    logic [AXI_DATA_W/8-1:0] wstrb;
    logic                    wvalid;
    logic                    wready;
    logic [1:0]              bresp;
    logic                    bvalid;
    logic                    bready;
    logic [AXI_ADDR_W-1:0]   araddr;
    logic                    arvalid;
    logic                    arready;
    logic [AXI_DATA_W-1:0]   rdata;
    logic [1:0]              rresp;
    logic                    rvalid;
    logic                    rready;

    modport master (output awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
                    input  awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid);
    modport slave  (input  awaddr, awvalid, wdata, wstrb, wvalid, bready, araddr, arvalid, rready,
                    output awready, wready, bresp, bvalid, arready, rdata, rresp, rvalid);
endinterface

interface atan_job_if import cordic_pkg::*; ();
    logic                     start;  // one-cycle launch, only while ready
    logic signed [DATA_W-1:0] x;
    logic signed [DATA_W-1:0] y;
    logic                     ready;
    logic                     done;   // one-cycle, angle valid with it
    logic signed [DATA_W-1:0] angle;

    modport host   (output start, x, y, input  ready, done, angle);
    modport engine (input  start, x, y, output ready, done, angle);
endinterface

/* verilog/axil_regs.sv */
module axil_regs import axil_pkg::*, cordic_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    axil_if.slave     bus,
    atan_job_if.host  job
);

    logic                     aw_hold;  // address captured, waiting for data
    logic                     w_hold;   // data captured, waiting for address
    logic [AXI_ADDR_W-1:0]    aw_addr;
    logic [AXI_DATA_W-1:0]    w_data;
    logic [AXI_DATA_W/8-1:0]  w_strb;
    logic                     wr_go;
    logic                     wr_ok;
    logic signed [DATA_W-1:0] x_r;
    logic signed [DATA_W-1:0] y_r;
    logic signed [DATA_W-1:0] result_r;
    logic                     done_flag;
    logic [AXI_DATA_W-1:0]    rd_word;
    logic [1:0]               rd_resp;

    assign bus.awready = ~aw_hold & ~bus.bvalid;
    assign bus.wready  = ~w_hold & ~bus.bvalid;
    assign wr_go       = aw_hold & w_hold;
    assign wr_ok       = (aw_addr == ADDR_X) || (aw_addr == ADDR_Y) || (aw_addr == ADDR_CTRL);

    assign job.x = x_r;
    assign job.y = y_r;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            aw_hold    <= 1'b0;
            w_hold     <= 1'b0;
            bus.bvalid <= 1'b0;
            bus.bresp  <= RESP_OKAY;
            job.start  <= 1'b0;
        end else begin
            job.start <= 1'b0;
            if (bus.awvalid && bus.awready)
                aw_hold <= 1'b1;
            if (bus.wvalid && bus.wready)
                w_hold <= 1'b1;
            if (wr_go) begin
                aw_hold    <= 1'b0;
                w_hold     <= 1'b0;
                bus.bvalid <= 1'b1;
                bus.bresp  <= wr_ok ? RESP_OKAY : RESP_SLVERR;
                // command is dropped when the engine is occupied
                job.start  <= (aw_addr == ADDR_CTRL) && w_strb[0] && w_data[0] && job.ready;
            end else if (bus.bvalid && bus.bready) begin
                bus.bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (bus.awvalid && bus.awready)
            aw_addr <= bus.awaddr;
        if (bus.wvalid && bus.wready) begin
            w_data <= bus.wdata;
            w_strb <= bus.wstrb;
        end
        if (wr_go) begin
            for (int b = 0; b < DATA_W / 8; b++) begin
                if (w_strb[b] && aw_addr == ADDR_X)
                    x_r[8*b +: 8] <= w_data[8*b +: 8];
                if (w_strb[b] && aw_addr == ADDR_Y)
                    y_r[8*b +: 8] <= w_data[8*b +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_flag <= 1'b0;
            result_r  <= '0;
        end else if (job.done) begin
            done_flag <= 1'b1;
            result_r  <= job.angle;  // held while the next job runs
        end else if (job.start) begin
            done_flag <= 1'b0;
        end
    end

    always_comb begin
        rd_resp = RESP_OKAY;
        case (bus.araddr)
            ADDR_X:      rd_word = {{(AXI_DATA_W-DATA_W){x_r[DATA_W-1]}}, x_r};
            ADDR_Y:      rd_word = {{(AXI_DATA_W-DATA_W){y_r[DATA_W-1]}}, y_r};
            ADDR_CTRL:   rd_word = '0;  // start bit is self-clearing
            ADDR_STATUS: rd_word = {{(AXI_DATA_W-2){1'b0}}, done_flag, ~job.ready};
            ADDR_RESULT: rd_word = {{(AXI_DATA_W-DATA_W){result_r[DATA_W-1]}}, result_r};
            default: begin
                rd_word = '0;
                rd_resp = RESP_SLVERR;
            end
        endcase
    end

    assign bus.arready = ~bus.rvalid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            bus.rvalid <= 1'b0;
            bus.rresp  <= RESP_OKAY;
        end else if (bus.arvalid && bus.arready) begin
            bus.rvalid <= 1'b1;
            bus.rresp  <= rd_resp;
        end else if (bus.rvalid && bus.rready) begin
            bus.rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (bus.arvalid && bus.arready)
            bus.rdata <= rd_word;  // frozen until rready
    end

endmodule

/* verilog/cordic_vectoring.sv */
module cordic_vectoring import cordic_pkg::*; (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     start,
    input  logic        [DATA_W:0]   x_in,   // first-quadrant magnitude
    input  logic        [DATA_W:0]   y_in,
    output logic                     idle,
    output logic                     finish,
    output logic signed [DATA_W-1:0] z_out
);

    logic                     busy;
    logic [ITER_W-1:0]        iter;
    logic signed [XY_W-1:0]   x_r;
    logic signed [XY_W-1:0]   y_r;
    logic signed [XY_W-1:0]   x_nxt;
    logic signed [XY_W-1:0]   y_nxt;
    logic signed [DATA_W-1:0] z_r;
    logic signed [DATA_W-1:0] z_nxt;
    logic                     last;

    // one micro-rotation per cycle, driving y towards zero
    always_comb begin
        if (!y_r[XY_W-1]) begin
            x_nxt = x_r + (y_r >>> iter);
            y_nxt = y_r - (x_r >>> iter);
            z_nxt = z_r + ATAN_TABLE[iter];
        end else begin
            x_nxt = x_r - (y_r >>> iter);
            y_nxt = y_r + (x_r >>> iter);
            z_nxt = z_r - ATAN_TABLE[iter];
        end
    end

    // stop on the final table entry or once the vector lies on the x axis
    assign last = (iter == ITER_W'(ITER_N - 1)) || (y_nxt == '0);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            iter   <= '0;
            finish <= 1'b0;
        end else begin
            finish <= 1'b0;
            if (start && !busy) begin
                busy <= 1'b1;
                iter <= '0;
            end else if (busy) begin
                iter <= iter + 1'b1;
                if (last) begin
                    busy   <= 1'b0;
                    finish <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start && !busy) begin
            x_r <= {{(XY_W-DATA_W-1-GUARD_W){1'b0}}, x_in, {GUARD_W{1'b0}}};
            y_r <= {{(XY_W-DATA_W-1-GUARD_W){1'b0}}, y_in, {GUARD_W{1'b0}}};
            z_r <= '0;
        end else if (busy) begin
            x_r <= x_nxt;
            y_r <= y_nxt;
            z_r <= z_nxt;
        end
    end

    assign idle  = ~busy;
    assign z_out = z_r;  // holds after finish until the next load

endmodule

/* verilog/atan2_engine.sv */
module atan2_engine import cordic_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    atan_job_if.engine  job
);

    logic signed [DATA_W:0]   x_ext;
    logic signed [DATA_W:0]   y_ext;
    logic        [DATA_W:0]   x_mag;  // one bit wider so -32768 folds
    logic        [DATA_W:0]   y_mag;
    logic                     core_start;
    logic                     core_idle;
    logic                     core_finish;
    logic signed [DATA_W-1:0] core_z;
    logic                     busy;
    logic                     x_neg;
    logic                     y_neg;
    logic                     both_zero;
    logic signed [DATA_W-1:0] a_clip;
    logic signed [DATA_W-1:0] a_fold;
    logic signed [DATA_W-1:0] a_full;

    assign x_ext = {job.x[DATA_W-1], job.x};
    assign y_ext = {job.y[DATA_W-1], job.y};
    assign x_mag = x_ext[DATA_W] ? -x_ext : x_ext;
    assign y_mag = y_ext[DATA_W] ? -y_ext : y_ext;

    assign core_start = job.start & core_idle;

    cordic_vectoring u_core (
        .clk    (clk),
        .rst_n  (rst_n),
        .start  (core_start),
        .x_in   (x_mag),
        .y_in   (y_mag),
        .idle   (core_idle),
        .finish (core_finish),
        .z_out  (core_z)
    );

    always_ff @(posedge clk) begin
        if (job.start) begin
            x_neg     <= job.x[DATA_W-1];
            y_neg     <= job.y[DATA_W-1];
            both_zero <= (job.x == '0) && (job.y == '0);
        end
    end

    always_comb begin
        a_clip = core_z[DATA_W-1] ? '0 : core_z;  // residue below zero when y is 0
        a_fold = x_neg ? HALF_TURN - a_clip : a_clip;
        if (both_zero)
            a_full = '0;
        else
            a_full = y_neg ? -a_fold : a_fold;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy     <= 1'b0;
            job.done <= 1'b0;
        end else begin
            job.done <= core_finish;
            if (job.start)
                busy <= 1'b1;
            else if (job.done)
                busy <= 1'b0;  // ready again the cycle after done
        end
    end

    always_ff @(posedge clk) begin
        if (core_finish)
            job.angle <= a_full;
    end

    assign job.ready = ~busy;

endmodule

/* verilog/atan_accel_top.sv */
module atan_accel_top import axil_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic [AXI_ADDR_W-1:0]   s_axil_awaddr,
    input  logic                    s_axil_awvalid,
    output logic                    s_axil_awready,
    input  logic [AXI_DATA_W-1:0]   s_axil_wdata,
    input  logic [AXI_DATA_W/8-1:0] s_axil_wstrb,
    input  logic                    s_axil_wvalid,
    output logic                    s_axil_wready,
    output logic [1:0]              s_axil_bresp,
    output logic                    s_axil_bvalid,
    input  logic                    s_axil_bready,
    input  logic [AXI_ADDR_W-1:0]   s_axil_araddr,
    input  logic                    s_axil_arvalid,
    output logic                    s_axil_arready,
    output logic [AXI_DATA_W-1:0]   s_axil_rdata,
    output logic [1:0]              s_axil_rresp,
    output logic                    s_axil_rvalid,
    input  logic                    s_axil_rready
);

    axil_if     bus ();
    atan_job_if job ();

    // host side of the bus bundle
    assign bus.awaddr  = s_axil_awaddr;
    assign bus.awvalid = s_axil_awvalid;
    assign bus.wdata   = s_axil_wdata;
    assign bus.wstrb   = s_axil_wstrb;
    assign bus.wvalid  = s_axil_wvalid;
    assign bus.bready  = s_axil_bready;
    assign bus.araddr  = s_axil_araddr;
    assign bus.arvalid = s_axil_arvalid;
    assign bus.rready  = s_axil_rready;

    assign s_axil_awready = bus.awready;
    assign s_axil_wready  = bus.wready;
    assign s_axil_bresp   = bus.bresp;
    assign s_axil_bvalid  = bus.bvalid;
    assign s_axil_arready = bus.arready;
    assign s_axil_rdata   = bus.rdata;
    assign s_axil_rresp   = bus.rresp;
    assign s_axil_rvalid  = bus.rvalid;

    axil_regs u_regs (
        .clk   (clk),
        .rst_n (rst_n),
        .bus   (bus.slave),
        .job   (job.host)
    );

    atan2_engine u_engine (
        .clk   (clk),
        .rst_n (rst_n),
        .job   (job.engine)
    );

endmodule

/* dv/atan_accel_props.sv */
module atan_accel_props import axil_pkg::*; (
    input logic                  clk,
    input logic                  rst_n,
    input logic                  bvalid,
    input logic                  bready,
    input logic [1:0]            bresp,
    input logic                  rvalid,
    input logic                  rready,
    input logic [AXI_DATA_W-1:0] rdata,
    input logic [1:0]            rresp,
    input logic                  start,
    input logic                  ready,
    input logic                  done
);
    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;  // assertion failures seen so far

    b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
        fail_count++;
        $error("write response dropped or changed before bready");
    end

    r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
    else begin
        fail_count++;
        $error("read response dropped or changed before rready");
    end

    start_gated: assert property (@(posedge clk) disable iff (!rst_n) start |-> ready)
    else begin
        fail_count++;
        $error("job started while the engine was not ready");
    end

    done_pulse: assert property (@(posedge clk) disable iff (!rst_n) done |=> !done)
    else begin
        fail_count++;
        $error("done lasted longer than one cycle");
    end

    // first edge out of reset
    reset_quiet: assert property (@(posedge clk) $rose(rst_n) |-> !bvalid && !rvalid)
    else begin
        fail_count++;
        $error("bus response valid right after reset");
    end

endmodule

bind atan_accel_top atan_accel_props u_props (
    .clk    (clk),
    .rst_n  (rst_n),
    .bvalid (s_axil_bvalid),
    .bready (s_axil_bready),
    .bresp  (s_axil_bresp),
    .rvalid (s_axil_rvalid),
    .rready (s_axil_rready),
    .rdata  (s_axil_rdata),
    .rresp  (s_axil_rresp),
    .start  (job.start),
    .ready  (job.ready),
    .done   (job.done)
);

/* dv/atan_accel_tb.sv */
module atan_accel_tb import axil_pkg::*, cordic_pkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int  N_RAND   = 24;
    localparam int  N_JOBS   = N_RAND + 9;  // fixed cases and register tests count as jobs
    localparam int  WD_CYC   = N_JOBS * (ITER_N + 40) + 4;
    localparam real PI       = 3.14159265358979;

    logic                    clk;
    logic                    rst_n = 1'b0;
    logic [AXI_ADDR_W-1:0]   awaddr = '0;
    logic                    awvalid = 1'b0;
    logic                    awready;
    logic [AXI_DATA_W-1:0]   wdata = '0;
    logic [AXI_DATA_W/8-1:0] wstrb = '0;
    logic                    wvalid = 1'b0;
    logic                    wready;
    logic [1:0]              bresp;
    logic                    bvalid;
    logic                    bready = 1'b0;
    logic [AXI_ADDR_W-1:0]   araddr = '0;
    logic                    arvalid = 1'b0;
    logic                    arready;
    logic [AXI_DATA_W-1:0]   rdata;
    logic [1:0]              rresp;
    logic                    rvalid;
    logic                    rready = 1'b0;
    logic [31:0]             lfsr = 32'hf7a9;
    int                      errors = 0;

    atan_accel_top dut (
        .clk(clk), .rst_n(rst_n),
        .s_axil_awaddr(awaddr), .s_axil_awvalid(awvalid), .s_axil_awready(awready),
        .s_axil_wdata(wdata), .s_axil_wstrb(wstrb), .s_axil_wvalid(wvalid),
        .s_axil_wready(wready), .s_axil_bresp(bresp), .s_axil_bvalid(bvalid),
        .s_axil_bready(bready), .s_axil_araddr(araddr), .s_axil_arvalid(arvalid),
        .s_axil_arready(arready), .s_axil_rdata(rdata), .s_axil_rresp(rresp),
        .s_axil_rvalid(rvalid), .s_axil_rready(rready)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        #(WD_CYC * 100);
        $display("Timeout: the tests did not finish in %0d cycles", WD_CYC);
        $display("SIMULATION FAILED");
        $finish;
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // atan2(y, x) / pi in 2^15 units, rounded to nearest
    function automatic logic [31:0] ref_angle(input int x, input int y);
        real a;
        int  q;
        a = $atan2(real'(y), real'(x)) / PI * 32768.0;
        q = $rtoi(a < 0.0 ? a - 0.5 : a + 0.5);
        if (q > 32767)
            q = 32767;
        return 32'(q);
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act,
                             input int tol);
        int diff;
        diff = $signed(act) - $signed(exp);
        assert (diff <= tol && diff >= -tol)
        else begin
            errors++;
            $display("Error %s expected %h actual %h", name, exp, act);
        end
    endtask

    // called and returns on a falling edge; stall holds bready low that many cycles
    task automatic bus_write(input logic [4:0] addr, input logic [31:0] data, input int stall,
                             output logic [1:0] resp);
        logic aw_hs;
        logic w_hs;
        awaddr  = addr;
        awvalid = 1'b1;
        wdata   = data;
        wstrb   = 4'hf;
        wvalid  = 1'b1;
        while (awvalid || wvalid) begin
            aw_hs = awvalid && awready;
            w_hs  = wvalid && wready;
            @(negedge clk);
            if (aw_hs)
                awvalid = 1'b0;
            if (w_hs)
                wvalid = 1'b0;
        end
        while (!bvalid)
            @(negedge clk);
        check_val("awready", 32'h0, awready, 0);  // no new write while a response is pending
        check_val("wready", 32'h0, wready, 0);
        repeat (stall) @(negedge clk);
        resp   = bresp;
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
    endtask

    task automatic bus_read(input logic [4:0] addr, input int stall, output logic [31:0] data,
                            output logic [1:0] resp);
        araddr  = addr;
        arvalid = 1'b1;
        while (!arready)
            @(negedge clk);
        @(negedge clk);
        arvalid = 1'b0;
        while (!rvalid)
            @(negedge clk);
        check_val("arready", 32'h0, arready, 0);
        repeat (stall) @(negedge clk);
        data   = rdata;
        resp   = rresp;
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
    endtask

    task automatic wait_done();
        logic [31:0] d;
        logic [1:0]  r;
        d = '0;
        while (!d[1])
            bus_read(ADDR_STATUS, 0, d, r);  // poll done_flag
    endtask

    task automatic run_job(input logic signed [15:0] x, input logic signed [15:0] y,
                           input int stall);
        logic [31:0] d;
        logic [1:0]  r;
        bus_write(ADDR_X, 32'(x), 0, r);
        bus_write(ADDR_Y, 32'(y), stall, r);
        bus_write(ADDR_CTRL, 32'h1, 0, r);
        check_val("bresp CTRL", RESP_OKAY, r, 0);
        wait_done();
        bus_read(ADDR_RESULT, stall, d, r);
        check_val("rdata RESULT", ref_angle(x, y), d, 4);
    endtask

    initial begin
        logic [31:0]        v;
        logic [31:0]        d;
        logic [1:0]         r;
        logic signed [15:0] xs;
        logic signed [15:0] ys;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        check_val("awready", 32'h1, awready, 0);
        check_val("arready", 32'h1, arready, 0);
        bus_read(ADDR_STATUS, 0, d, r);
        check_val("rdata STATUS", 32'h0, d, 0);
        bus_read(ADDR_RESULT, 0, d, r);
        check_val("rdata RESULT", 32'h0, d, 0);
        bus_write(5'h14, 32'h1, 0, r);  // unmapped
        check_val("bresp", RESP_SLVERR, r, 0);
        bus_write(ADDR_STATUS, 32'h1, 1, r);
        check_val("bresp", RESP_SLVERR, r, 0);
        bus_read(5'h1c, 2, d, r);
        check_val("rresp", RESP_SLVERR, r, 0);
        check_val("rdata", 32'h0, d, 0);
        run_job(16'sd1200, 16'sd0, 0);
        run_job(-16'sd1200, 16'sd0, 1);
        run_job(16'sd0, 16'sd900, 0);
        run_job(16'sd0, -16'sd900, 2);
        run_job(16'sd0, 16'sd0, 0);
        run_job(16'sd2000, 16'sd2000, 3);  // stops early at 8192
        run_job(16'sh8000, 16'sh8000, 0);
        // second start while busy is dropped
        bus_write(ADDR_X, 32'd12345, 0, r);
        bus_write(ADDR_Y, 32'd6789, 0, r);
        bus_write(ADDR_CTRL, 32'h1, 0, r);
        bus_read(ADDR_STATUS, 0, d, r);
        check_val("rdata STATUS.busy", 32'h1, {31'b0, d[0]}, 0);
        bus_write(ADDR_X, 32'hffff_8000, 0, r);
        bus_write(ADDR_CTRL, 32'h1, 0, r);
        wait_done();
        bus_read(ADDR_RESULT, 0, d, r);
        check_val("rdata RESULT", ref_angle(12345, 6789), d, 4);
        bus_read(ADDR_X, 2, d, r);
        check_val("rdata X", 32'hffff_8000, d, 0);
        bus_read(ADDR_Y, 0, d, r);
        check_val("rdata Y", 32'd6789, d, 0);
        for (int i = 0; i < N_RAND; i++) begin
            draw_bits(15, v);
            xs = {1'b0, v[14:0]};
            if (i[0])
                xs = -xs;  // quadrant taken from the loop index
            draw_bits(15, v);
            ys = {1'b0, v[14:0]};
            if (i[1])
                ys = -ys;
            draw_bits(2, v);
            run_job(xs, ys, int'(v));
        end
        $display("Value errors: %0d, protocol errors: %0d", errors, dut.u_props.fail_count);
        if (errors == 0 && dut.u_props.fail_count == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* filelist.f */
verilog/cordic_pkg.sv
verilog/axil_pkg.sv
verilog/axil_if.sv
verilog/axil_regs.sv
verilog/cordic_vectoring.sv
verilog/atan2_engine.sv
verilog/atan_accel_top.sv
dv/atan_accel_props.sv
dv/atan_accel_tb.sv
